// ==== list.f ====
+incdir+rtl
rtl/blit_pkg.sv
rtl/inner_cnt.sv
rtl/blit_seq.sv
rtl/blit_regs.sv
rtl/blit_top.sv
verif/blit_props.sv
verif/blit_tb.sv

// ==== rtl/blit_macros.svh ====
// Blitter counter constants
`ifndef BLIT_MACROS_SVH
`define BLIT_MACROS_SVH

// Width of the inner count, line count and x pointer
`define BLIT_CNT_W 16

// Width of a step, pixels covered by one write beat
`define BLIT_STEP_W 4

// AXI4-Lite register byte offsets
`define BLIT_REG_CMD    4'h0
`define BLIT_REG_COUNT  4'h4
`define BLIT_REG_DSTX   4'h8
`define BLIT_REG_STATUS 4'hC

// Pixel size codes, log2 of bits per pixel
`define BLIT_PIX8  3'd3
`define BLIT_PIX16 3'd4
`define BLIT_PIX32 3'd5

`endif

// ==== rtl/blit_pkg.sv ====
// Blitter shared types
package blit_pkg;

	// Command word as the sequencer sees it
	// Start bit sits at the top of the word
	typedef struct packed {
		logic        start;
		logic        phrase_mode;
		// Pixel size code, see the BLIT_PIX macros
		logic [2:0]  pixsize;
		// Ignored, stored and read back as written
		logic [26:0] reserved;
	} blit_cmd_s;

	// One command word, two views
	// Register block works on the raw word
	// Sequencer decodes the fields
	typedef union packed {
		logic [31:0] raw;
		blit_cmd_s   fields;
	} blit_cmd_u;

endpackage

// ==== rtl/blit_regs.sv ====
// Blitter AXI4-Lite register block
`include "blit_macros.svh"

module blit_regs (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic [3:0]             awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [31:0]            wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  logic [3:0]             araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [31:0]            rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	output blit_pkg::blit_cmd_u    cmd,
	output logic                   go,
	output logic                   countld,
	output logic [`BLIT_CNT_W-1:0] cnt_din,
	output logic [`BLIT_CNT_W-1:0] lines,
	output logic [`BLIT_CNT_W-1:0] dstx_start,
	input  logic [`BLIT_CNT_W-1:0] icount,
	input  logic                   busy,
	input  logic                   done
);

	logic                wr_hs;
	logic                rd_hs;
	// Merged write words, old bytes kept where the strobe is low
	blit_pkg::blit_cmd_u cmd_wr;
	blit_pkg::blit_cmd_u cmd_store;
	logic [31:0]         count_wr;
	logic [31:0]         dstx_wr;
	logic [31:0]         status_word;

	// Byte lane merge
	function automatic logic [31:0] apply_strb(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] result;
		result = old_word;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				result[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return result;
	endfunction

	// Address and data accepted together, one write in flight
	assign wr_hs   = awvalid & wvalid & ~bvalid;
	assign awready = wr_hs;
	assign wready  = wr_hs;
	assign bresp   = 2'b00;

	assign arready = ~rvalid;
	assign rd_hs   = arvalid & arready;
	assign rresp   = 2'b00;

	assign cmd_wr.raw = apply_strb(cmd.raw, wdata, wstrb);
	assign count_wr   = apply_strb({lines, cnt_din}, wdata, wstrb);
	assign dstx_wr    = apply_strb({{(32 - `BLIT_CNT_W){1'b0}}, dstx_start}, wdata, wstrb);

	// Start is a trigger only, never stored
	always_comb begin
		cmd_store              = cmd_wr;
		cmd_store.fields.start = 1'b0;
	end

	assign status_word = {icount, 14'd0, done, busy};

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			bvalid     <= 1'b0;
			rvalid     <= 1'b0;
			go         <= 1'b0;
			countld    <= 1'b0;
			cmd.raw    <= '0;
			cnt_din    <= '0;
			lines      <= '0;
			dstx_start <= '0;
		end else begin
			// Pulses line up with bvalid
			go      <= wr_hs && (awaddr == `BLIT_REG_CMD) && cmd_wr.fields.start;
			countld <= wr_hs && (awaddr == `BLIT_REG_COUNT);
			if (wr_hs) begin
				bvalid <= 1'b1;
				case (awaddr)
					`BLIT_REG_CMD: cmd <= cmd_store;
					`BLIT_REG_COUNT: begin
						cnt_din <= count_wr[15:0];
						lines   <= count_wr[31:16];
					end
					`BLIT_REG_DSTX: dstx_start <= dstx_wr[`BLIT_CNT_W-1:0];
					// Status and unmapped offsets drop the write
					default: ;
				endcase
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rd_hs) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Read data captured at the address handshake
	always_ff @(posedge sys_clk) begin
		if (rd_hs) begin
			case (araddr)
				`BLIT_REG_CMD:    rdata <= cmd.raw;
				`BLIT_REG_COUNT:  rdata <= {lines, cnt_din};
				`BLIT_REG_DSTX:   rdata <= {{(32 - `BLIT_CNT_W){1'b0}}, dstx_start};
				`BLIT_REG_STATUS: rdata <= status_word;
				default:          rdata <= 32'd0;
			endcase
		end
	end

endmodule

// ==== rtl/blit_seq.sv ====
// Blitter line sequencer
`include "blit_macros.svh"

module blit_seq (
	input  logic                    sys_clk,
	input  logic                    rst_n,
	input  logic                    go,
	input  blit_pkg::blit_cmd_u     cmd,
	input  logic [`BLIT_CNT_W-1:0]  lines,
	input  logic [`BLIT_CNT_W-1:0]  dstx_start,
	input  logic [`BLIT_STEP_W-1:0] step,
	input  logic [`BLIT_CNT_W-1:0]  icount,
	input  logic                    inner0,
	input  logic                    wr_ready,
	output logic                    wr_valid,
	output logic [`BLIT_CNT_W-1:0]  wr_x,
	output logic [`BLIT_STEP_W-1:0] wr_npix,
	output logic                    icntena,
	output logic                    ireload,
	output logic                    busy,
	output logic                    done,
	output logic                    phrase_mode,
	output logic [2:0]              pixsize,
	output logic [2:0]              dstxp
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_RUN    = 2'd1;
	localparam logic [1:0] ST_RELOAD = 2'd2;

	logic [1:0]             state;
	logic [`BLIT_CNT_W-1:0] x_ptr;
	logic [`BLIT_CNT_W-1:0] x_start;
	logic [`BLIT_CNT_W-1:0] lines_left;
	logic [`BLIT_CNT_W-1:0] step_ext;
	logic                   last_beat;

	assign step_ext = {{(`BLIT_CNT_W - `BLIT_STEP_W){1'b0}}, step};

	// Beats only in RUN, the reload cycle is the line bubble
	assign wr_valid = (state == ST_RUN);
	assign icntena  = wr_valid & wr_ready;
	assign ireload  = (state == ST_RELOAD);
	assign busy     = (state != ST_IDLE);

	assign wr_x  = x_ptr;
	assign dstxp = x_ptr[2:0];
	// Clip the final beat of a line to the pixels left
	assign wr_npix   = (icount < step_ext) ? icount[`BLIT_STEP_W-1:0] : step;
	assign last_beat = (icount <= step_ext);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state       <= ST_IDLE;
			done        <= 1'b0;
			x_ptr       <= '0;
			x_start     <= '0;
			lines_left  <= '0;
			phrase_mode <= 1'b0;
			pixsize     <= `BLIT_PIX8;
		end else begin
			case (state)
				ST_IDLE: begin
					if (go) begin
						// Command fields frozen for the whole blit
						phrase_mode <= cmd.fields.phrase_mode;
						pixsize     <= cmd.fields.pixsize;
						x_ptr       <= dstx_start;
						x_start     <= dstx_start;
						lines_left  <= lines;
						// Counter holds the width here, zero width shows as inner0
						if (inner0 || (lines == '0)) begin
							done <= 1'b1;
						end else begin
							done  <= 1'b0;
							state <= ST_RUN;
						end
					end
				end
				ST_RUN: begin
					if (icntena) begin
						x_ptr <= x_ptr + step_ext;
						if (last_beat) begin
							state <= ST_RELOAD;
						end
					end
				end
				ST_RELOAD: begin
					// Counter reloads on this edge as well, also after the last line
					x_ptr <= x_start;
					if (lines_left == 'd1) begin
						state <= ST_IDLE;
						done  <= 1'b1;
					end else begin
						lines_left <= lines_left - 1'b1;
						state      <= ST_RUN;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/blit_top.sv ====
// Blitter inner loop top
`include "blit_macros.svh"

module blit_top (
	input  logic                    sys_clk,
	input  logic                    rst_n,
	input  logic [3:0]              awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [31:0]             wdata,
	input  logic [3:0]              wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [3:0]              araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [31:0]             rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	output logic                    wr_valid,
	input  logic                    wr_ready,
	output logic [`BLIT_CNT_W-1:0]  wr_x,
	output logic [`BLIT_STEP_W-1:0] wr_npix
);

	blit_pkg::blit_cmd_u     cmd;
	logic                    go;
	logic                    countld;
	logic [`BLIT_CNT_W-1:0]  cnt_din;
	logic [`BLIT_CNT_W-1:0]  lines;
	logic [`BLIT_CNT_W-1:0]  dstx_start;
	logic [`BLIT_CNT_W-1:0]  icount;
	logic                    busy;
	logic                    done;
	logic [`BLIT_STEP_W-1:0] step;
	logic                    inner0;
	logic                    icntena;
	logic                    ireload;
	logic                    phrase_mode;
	logic [2:0]              pixsize;
	logic [2:0]              dstxp;

	// Host registers and status
	blit_regs i_regs (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.cmd(cmd), .go(go), .countld(countld), .cnt_din(cnt_din),
		.lines(lines), .dstx_start(dstx_start),
		.icount(icount), .busy(busy), .done(done)
	);

	// Lines, x pointer and beat handshake
	blit_seq i_seq (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.go(go), .cmd(cmd), .lines(lines), .dstx_start(dstx_start),
		.step(step), .icount(icount), .inner0(inner0), .wr_ready(wr_ready),
		.wr_valid(wr_valid), .wr_x(wr_x), .wr_npix(wr_npix),
		.icntena(icntena), .ireload(ireload), .busy(busy), .done(done),
		.phrase_mode(phrase_mode), .pixsize(pixsize), .dstxp(dstxp)
	);

	// Pixels left in the line and phrase step
	inner_cnt i_cnt (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.countld(countld), .cnt_din(cnt_din),
		.icntena(icntena), .ireload(ireload),
		.phrase_mode(phrase_mode), .pixsize(pixsize), .dstxp(dstxp),
		.step(step), .icount(icount), .inner0(inner0)
	);

endmodule

// ==== rtl/inner_cnt.sv ====
// Inner pixel counter
`include "blit_macros.svh"

module inner_cnt (
	input  logic                    sys_clk,
	input  logic                    rst_n,
	input  logic                    countld,
	input  logic [`BLIT_CNT_W-1:0]  cnt_din,
	input  logic                    icntena,
	input  logic                    ireload,
	input  logic                    phrase_mode,
	input  logic [2:0]              pixsize,
	input  logic [2:0]              dstxp,
	output logic [`BLIT_STEP_W-1:0] step,
	output logic [`BLIT_CNT_W-1:0]  icount,
	output logic                    inner0
);

	// Line width kept for every reload
	logic [`BLIT_CNT_W-1:0] cnt_reload;
	// Delayed load strobe, count follows the reload value one edge late
	logic                   cntld_q;
	// Sticky flag, last step went past zero
	logic                   underflow;
	// Pixels up to the next 64-bit phrase boundary
	logic [`BLIT_STEP_W-1:0] phrase_step;
	// Count minus step, top bit is the borrow
	logic [`BLIT_CNT_W:0]   count_dec;

	// Phrase holds 8, 4 or 2 pixels
	// Distance to boundary from the low x bits
	always_comb begin
		case (pixsize)
			`BLIT_PIX8:  phrase_step = 4'd8 - {1'b0, dstxp};
			`BLIT_PIX16: phrase_step = 4'd4 - {2'b00, dstxp[1:0]};
			`BLIT_PIX32: phrase_step = 4'd2 - {3'b000, dstxp[0]};
			// Unsupported sizes fall back to single pixels
			default:     phrase_step = 4'd1;
		endcase
	end

	// One pixel per beat outside phrase mode
	assign step = phrase_mode ? phrase_step : 4'd1;

	// Zero-extended subtract so the borrow shows crossing below zero
	assign count_dec = {1'b0, icount} -
		{{(`BLIT_CNT_W + 1 - `BLIT_STEP_W){1'b0}}, step};

	// Reload value written straight from the register block
	always_ff @(posedge sys_clk) begin
		if (countld) begin
			cnt_reload <= cnt_din;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			cntld_q   <= 1'b0;
			icount    <= '0;
			underflow <= 1'b0;
		end else begin
			cntld_q <= countld;
			if (cntld_q || ireload) begin
				// New line, flag from the previous line no longer applies
				icount    <= cnt_reload;
				underflow <= 1'b0;
			end else if (icntena) begin
				icount    <= count_dec[`BLIT_CNT_W-1:0];
				underflow <= count_dec[`BLIT_CNT_W];
			end
		end
	end

	// End of line on exact zero or after a clipped step
	assign inner0 = (icount == '0) | underflow;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the blitter testbench with Verilator
set -e
cd "$(dirname "$0")"

build_dir=build
log="$build_dir/sim.log"
mkdir -p "$build_dir"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module blit_tb -Mdir "$build_dir/obj" -f list.f
"$build_dir/obj/Vblit_tb" | tee "$log"

if grep -qx "TEST PASSED" "$log"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== verif/blit_props.sv ====
// Blitter handshake and counter checks
`include "blit_macros.svh"

module blit_props (
	input logic                    sys_clk,
	input logic                    rst_n,
	input logic                    wr_valid,
	input logic                    wr_ready,
	input logic [`BLIT_CNT_W-1:0]  wr_x,
	input logic [`BLIT_STEP_W-1:0] wr_npix,
	input logic                    bvalid,
	input logic                    bready,
	input logic                    ireload,
	input logic [`BLIT_CNT_W-1:0]  icount,
	input logic                    busy,
	input logic                    done
);
	timeunit 1ns;
	timeprecision 1ps;

	// Beat held while stalled
	a_beat_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_x) && $stable(wr_npix)))
		else $error("write beat changed while stalled");

	// Write response held until taken
	a_bresp_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(bvalid && !bready) |=> bvalid)
		else $error("bvalid dropped before bready");

	// Count only moves on an accepted beat or a line reload
	a_cnt_ena: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(busy && !(wr_valid && wr_ready) && !ireload) |=> $stable(icount))
		else $error("inner count moved without an accepted beat");

	a_busy_done: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(busy && done))
		else $error("busy and done both high");

endmodule

bind blit_top blit_props i_props (
	.sys_clk(sys_clk), .rst_n(rst_n), .wr_valid(wr_valid), .wr_ready(wr_ready),
	.wr_x(wr_x), .wr_npix(wr_npix), .bvalid(bvalid), .bready(bready),
	.ireload(ireload), .icount(icount), .busy(busy), .done(done)
);

// ==== verif/blit_tb.sv ====
// Blitter inner loop testbench
`include "blit_macros.svh"

module blit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int axi_limit = 20;
	localparam int poll_limit = 400;

	logic                    sys_clk;
	logic                    rst_n;
	logic [3:0]              awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [31:0]             wdata;
	logic [3:0]              wstrb;
	logic                    wvalid;
	logic                    wready;
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	logic [3:0]              araddr;
	logic                    arvalid;
	logic                    arready;
	logic [31:0]             rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;
	logic                    wr_valid;
	logic                    wr_ready;
	logic [`BLIT_CNT_W-1:0]  wr_x;
	logic [`BLIT_STEP_W-1:0] wr_npix;

	integer      seed;
	logic        bp_on;
	// Expected beats, x in the upper bits and npix in the low nibble
	logic [19:0] exp_q[$];
	logic [19:0] next_beat;
	int          err_count;
	int          tests_run;
	int          tests_failed;

	blit_top i_dut (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_x(wr_x), .wr_npix(wr_npix)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Phrase of 64 bits, beat runs to the next boundary, last beat clipped
	function automatic void build_expected(input logic [15:0] width, input logic [15:0] nlines,
		input logic [15:0] x0, input logic phrase, input logic [2:0] pix);
		int ln;
		int x;
		int left;
		int ppp;
		int stp;
		int n;
		ppp = 64 >> pix;
		for (ln = 0; ln < int'(nlines); ln++) begin
			x = int'(x0);
			left = int'(width);
			while (left > 0) begin
				stp = phrase ? ppp - (x % ppp) : 1;
				n = (left < stp) ? left : stp;
				exp_q.push_back({x[15:0], n[3:0]});
				x += stp;
				left -= stp;
			end
		end
	endfunction

	task automatic compare_beat(input logic [`BLIT_CNT_W-1:0] exp_x,
		input logic [`BLIT_CNT_W-1:0] got_x, input logic [`BLIT_STEP_W-1:0] exp_n,
		input logic [`BLIT_STEP_W-1:0] got_n);
		if (got_x !== exp_x || got_n !== exp_n) begin
			$display("mismatch at %0t: beat x %0d npix %0d, expected x %0d npix %0d",
				$time, got_x, got_n, exp_x, exp_n);
			err_count++;
		end
	endtask

	task automatic compare_status(input string what, input logic [31:0] exp_w,
		input logic [31:0] got_w);
		if (got_w !== exp_w) begin
			$display("mismatch at %0t: %s read %h, expected %h", $time, what, got_w, exp_w);
			err_count++;
		end
	endtask

	task automatic compare_cmd(input blit_pkg::blit_cmd_u exp_c, input blit_pkg::blit_cmd_u got_c);
		if (got_c.raw !== exp_c.raw) begin
			$display("mismatch at %0t: CMD read %h, expected %h", $time, got_c.raw, exp_c.raw);
			err_count++;
		end
	endtask

	task automatic compare_resp(input string what, input logic [1:0] exp_r,
		input logic [1:0] got_r);
		if (got_r !== exp_r) begin
			$display("mismatch at %0t: %s response %b, expected %b", $time, what, got_r, exp_r);
			err_count++;
		end
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		int   cycles;
		logic accepted;
		@(negedge sys_clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b0;
		cycles = 0;
		// Address and data taken together at a rising edge
		do begin
			@(posedge sys_clk);
			accepted = awready && wready;
			cycles++;
		end while (!accepted && cycles < axi_limit);
		@(negedge sys_clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!accepted) begin
			$display("Write to offset %h was not accepted within %0d cycles", addr, axi_limit);
			err_count++;
		end else if (!bvalid) begin
			$display("Write to offset %h got no response one cycle after the handshake", addr);
			err_count++;
		end else begin
			compare_resp("write", 2'b00, bresp);
			// Response must stay up while bready is held low
			@(negedge sys_clk);
			bready = 1'b1;
		end
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		int   cycles;
		logic accepted;
		@(negedge sys_clk);
		araddr = addr;
		arvalid = 1'b1;
		cycles = 0;
		do begin
			@(posedge sys_clk);
			accepted = arready;
			cycles++;
		end while (!accepted && cycles < axi_limit);
		@(negedge sys_clk);
		arvalid = 1'b0;
		data = rdata;
		if (!accepted) begin
			$display("Read from offset %h was not accepted within %0d cycles", addr, axi_limit);
			err_count++;
		end else if (!rvalid) begin
			$display("Read from offset %h got no data one cycle after the handshake", addr);
			err_count++;
		end else begin
			compare_resp("read", 2'b00, rresp);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (err_count == err_before) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed", name);
		end
	endtask

	task automatic run_blit(input string name, input logic [15:0] width,
		input logic [15:0] nlines, input logic [15:0] x0, input logic phrase,
		input logic [2:0] pix);
		blit_pkg::blit_cmd_u cmd;
		logic [31:0]         status;
		int                  polls;
		int                  err_before;
		err_before = err_count;
		build_expected(width, nlines, x0, phrase, pix);
		axi_write(`BLIT_REG_DSTX, {16'd0, x0});
		axi_write(`BLIT_REG_COUNT, {nlines, width});
		cmd.raw = 32'd0;
		cmd.fields.start = 1'b1;
		cmd.fields.phrase_mode = phrase;
		cmd.fields.pixsize = pix;
		axi_write(`BLIT_REG_CMD, cmd.raw);
		status = 32'd0;
		polls = 0;
		while (!status[1] && polls < poll_limit) begin
			axi_read(`BLIT_REG_STATUS, status);
			polls++;
		end
		if (!status[1]) begin
			$display("%s: done never set after %0d status reads", name, poll_limit);
			err_count++;
		end
		// Counter reloaded at each line end, so it holds the width when idle
		compare_status("STATUS after blit", {width, 14'd0, 2'b10}, status);
		if (exp_q.size() != 0) begin
			$display("%s: %0d expected beats never arrived", name, exp_q.size());
			err_count++;
		end
		exp_q.delete();
		end_test(name, err_before);
	endtask

	task automatic check_readback();
		blit_pkg::blit_cmd_u wr_cmd;
		blit_pkg::blit_cmd_u exp_cmd;
		logic [31:0]         rd;
		int                  err_before;
		err_before = err_count;
		// No lines, a start ends at once without beats
		axi_write(`BLIT_REG_COUNT, {16'd0, 16'd9});
		// Count follows two edges after the handshake
		@(negedge sys_clk);
		axi_read(`BLIT_REG_STATUS, rd);
		compare_status("STATUS after COUNT write", {16'd9, 14'd0, 2'b10}, rd);
		wr_cmd.raw = 32'd0;
		wr_cmd.fields.start = 1'b1;
		wr_cmd.fields.phrase_mode = 1'b1;
		wr_cmd.fields.pixsize = `BLIT_PIX16;
		wr_cmd.fields.reserved = 27'h2a5_5a5;
		exp_cmd = wr_cmd;
		exp_cmd.fields.start = 1'b0;
		axi_write(`BLIT_REG_CMD, wr_cmd.raw);
		axi_read(`BLIT_REG_CMD, rd);
		compare_cmd(exp_cmd, rd);
		axi_read(4'h6, rd);
		compare_status("unmapped offset", 32'd0, rd);
		end_test("register read-back", err_before);
	endtask

	// Ready drawn at the falling edge
	always @(negedge sys_clk) begin
		if (bp_on) begin
			wr_ready <= 1'($unsigned($random(seed)) % 2);
		end else begin
			wr_ready <= 1'b1;
		end
	end

	// Each accepted beat takes the next expected one
	always @(posedge sys_clk) begin
		if (rst_n && wr_valid && wr_ready) begin
			if (exp_q.size() == 0) begin
				$display("Beat at x %0d arrived with none expected, time %0t", wr_x, $time);
				err_count++;
			end else begin
				next_beat = exp_q.pop_front();
				compare_beat(next_beat[19:4], wr_x, next_beat[3:0], wr_npix);
			end
		end
	end

	initial begin
		int         i;
		logic [15:0] rw;
		logic [15:0] rl;
		logic [15:0] rx;
		logic [2:0]  rpix;
		logic        rphr;
		seed = 32'hfc12_02e2;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
		bp_on = 1'b0;
		rst_n = 1'b0;
		awaddr = 4'h0;
		awvalid = 1'b0;
		wdata = 32'd0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 4'h0;
		arvalid = 1'b0;
		rready = 1'b1;
		wr_ready = 1'b0;
		repeat (2) @(negedge sys_clk);
		rst_n = 1'b1;

		run_blit("single pixel", 16'd5, 16'd3, 16'd7, 1'b0, `BLIT_PIX8);
		run_blit("phrase 8 bpp", 16'd21, 16'd2, 16'd3, 1'b1, `BLIT_PIX8);
		run_blit("phrase 16 bpp", 16'd14, 16'd2, 16'd5, 1'b1, `BLIT_PIX16);
		run_blit("phrase 32 bpp", 16'd9, 16'd3, 16'd1, 1'b1, `BLIT_PIX32);
		run_blit("clipped last beat", 16'd11, 16'd3, 16'd2, 1'b1, `BLIT_PIX8);

		bp_on = 1'b1;
		for (i = 0; i < 6; i++) begin
			// Settings drawn on the rising edge, ready on the falling one
			@(posedge sys_clk);
			rw = 16'($unsigned($random(seed)) % 40 + 1);
			rl = 16'($unsigned($random(seed)) % 4 + 1);
			rx = 16'($unsigned($random(seed)) % 64);
			rpix = 3'(3 + $unsigned($random(seed)) % 3);
			rphr = 1'($unsigned($random(seed)) % 2);
			run_blit($sformatf("random back-pressure %0d", i), rw, rl, rx, rphr, rpix);
		end
		bp_on = 1'b0;

		run_blit("zero width", 16'd0, 16'd3, 16'd4, 1'b0, `BLIT_PIX8);
		run_blit("zero lines", 16'd6, 16'd0, 16'd4, 1'b1, `BLIT_PIX8);
		check_readback();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
